// ==== hdl/dp_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module dp_ram import tpu_pkg::*; (
  input  logic  clk,
  // internal port, owned by the engine
  input  addr_t int_addr,
  input  row_t  int_wdata,
  input  logic  int_we,
  output row_t  int_rdata,
  // external port, owned by the host
  input  addr_t ext_addr,
  input  row_t  ext_wdata,
  input  logic  ext_we,
  output row_t  ext_rdata
);

  row_t mem [0:(1<<AWIDTH)-1];

  // the external write comes last so it wins on an address clash
  always_ff @(posedge clk) begin
    if (int_we) begin
      mem[int_addr] <= int_wdata;
    end
    if (ext_we) begin
      mem[ext_addr] <= ext_wdata;
    end
  end

  // registered reads, old data on a read during write
  always_ff @(posedge clk) begin
    int_rdata <= mem[int_addr];
    ext_rdata <= mem[ext_addr];
  end

  // first edge skipped, the engine write flop is still being reset there
  write_enables_known: assert property (
    @(posedge clk) ##1 !$isunknown({int_we, ext_we})
  ) else $error("dp_ram: write enable is unknown");

endmodule

`default_nettype wire

// ==== hdl/norm_act.sv ====
`timescale 1ns/100ps
`default_nettype none

module norm_act import tpu_pkg::*; #(
  parameter int unsigned NORM_SHIFT = 4
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  row_t  in_row,
  input  lane_t mean,
  input  lane_t inv_var,
  input  logic  norm_enable,
  input  logic  relu_enable,
  output logic  out_valid,
  output row_t  out_row
);

  localparam logic signed [2*DWIDTH:0] SAT_MAX = (1 <<< (DWIDTH-1)) - 1;
  localparam logic signed [2*DWIDTH:0] SAT_MIN = -(1 <<< (DWIDTH-1));

  row_t next_row;

  // one lane through normalize then activate
  function automatic lane_t act_lane(input lane_t x);
    logic signed [DWIDTH:0]   diff;
    logic signed [2*DWIDTH:0] prod;
    logic signed [2*DWIDTH:0] shifted;
    lane_t                    y;
    diff    = x - mean;
    prod    = diff * inv_var;
    shifted = prod >>> NORM_SHIFT;
    if (!norm_enable) begin
      y = x;
    end else if (shifted > SAT_MAX) begin
      y = lane_t'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      y = lane_t'(SAT_MIN);
    end else begin
      y = shifted[DWIDTH-1:0];
    end
    // relu keys off the sign bit only
    if (relu_enable && y[DWIDTH-1]) begin
      y = '0;
    end
    return y;
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      next_row[i*DWIDTH +: DWIDTH] = act_lane(in_row[i*DWIDTH +: DWIDTH]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_row <= next_row;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/result_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_writer import tpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    run_start,
  input  addr_t   dst_addr,
  input  stride_t dst_stride,
  input  logic    out_valid,
  input  row_t    out_row,
  output addr_t   wr_addr,
  output row_t    wr_row,
  output logic    wr_en
);

  // address the next result row will land at
  addr_t next_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= out_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (run_start) begin
      next_addr <= dst_addr;
    end else if (out_valid) begin
      next_addr <= next_addr + addr_t'(dst_stride);
    end
  end

  // payload and its address captured together
  always_ff @(posedge clk) begin
    if (out_valid) begin
      wr_row  <= out_row;
      wr_addr <= next_addr;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/row_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_reader import tpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    run_start,
  input  addr_t   src_addr,
  input  stride_t src_stride,
  input  count_t  num_rows,
  input  logic    port_busy,
  output addr_t   rd_addr,
  output logic    rd_issue
);

  logic   active;
  count_t remaining;

  // a pending write owns the shared port, so hold off that cycle
  assign rd_issue = active && !port_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      remaining <= '0;
    end else if (run_start) begin
      active    <= (num_rows != '0);
      remaining <= num_rows;
    end else if (rd_issue) begin
      remaining <= remaining - 1'b1;
      if (remaining == count_t'(1)) begin
        active <= 1'b0;
      end
    end
  end

  // address walk from src_addr in steps of src_stride
  always_ff @(posedge clk) begin
    if (run_start) begin
      rd_addr <= src_addr;
    end else if (rd_issue) begin
      rd_addr <= rd_addr + addr_t'(src_stride);
    end
  end

  no_read_on_write: assert property (
    @(posedge clk) disable iff (reset)
    !(rd_issue && port_busy)
  ) else $error("row_reader: read issued while a write holds the port");

endmodule

`default_nettype wire

// ==== hdl/tpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module tpu_control import tpu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   start,
  input  count_t num_rows,
  input  logic   wr_en,
  output logic   run_start,
  output logic   busy,
  output logic   done
);

  ctrl_state_t state;
  count_t      wr_count;
  logic        last_write;

  assign last_write = wr_en && (count_t'(wr_count + 1'b1) == num_rows);
  assign busy = (state != CTRL_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= CTRL_IDLE;
      wr_count  <= '0;
      run_start <= 1'b0;
      done      <= 1'b0;
    end else begin
      run_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          // start only counts here, a pulse while busy is dropped
          if (start) begin
            state     <= CTRL_RUN;
            wr_count  <= '0;
            run_start <= 1'b1;
          end
        end
        CTRL_RUN: begin
          if (wr_en) begin
            wr_count <= wr_count + 1'b1;
          end
          if (last_write) begin
            state <= CTRL_DRAIN;
            done  <= 1'b1;
          end
        end
        CTRL_DRAIN: begin
          state <= CTRL_IDLE;
        end
        default: begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

  // done only ever follows a write seen during a run
  done_not_idle: assert property (
    @(posedge clk) disable iff (reset)
    $rose(done) |-> (state != CTRL_IDLE) && $past(wr_en)
  ) else $error("tpu_control: done raised outside a run");

endmodule

`default_nettype wire

// ==== hdl/tpu_pkg.sv ====
`default_nettype none

package tpu_pkg;

  ////////////////////////////////////////////////////////////
  // datapath geometry
  ////////////////////////////////////////////////////////////

  localparam int LANES  = 4;
  localparam int DWIDTH = 8;
  localparam int AWIDTH = 6;

  // one signed lane, lane 0 lives in the low bits of a row
  typedef logic signed [DWIDTH-1:0] lane_t;
  typedef logic [LANES*DWIDTH-1:0] row_t;

  typedef logic [AWIDTH-1:0] addr_t;
  typedef logic [3:0] stride_t;

  // one extra bit so a full 64-row count still fits
  typedef logic [AWIDTH:0] count_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_DRAIN
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/tpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tpu_top import tpu_pkg::*; #(
  parameter int unsigned NORM_SHIFT = 4
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  output logic    done,
  // configuration, held from start until done
  input  addr_t   src_addr,
  input  stride_t src_stride,
  input  addr_t   dst_addr,
  input  stride_t dst_stride,
  input  count_t  num_rows,
  input  lane_t   mean,
  input  lane_t   inv_var,
  input  logic    norm_enable,
  input  logic    relu_enable,
  // host port
  input  addr_t   ext_addr,
  input  row_t    ext_wdata,
  input  logic    ext_we,
  output row_t    ext_rdata
);

  logic  run_start;
  logic  busy;
  addr_t rd_addr;
  logic  rd_issue;
  logic  in_valid;
  row_t  int_rdata;
  addr_t int_addr;
  logic  out_valid;
  row_t  out_row;
  addr_t wr_addr;
  row_t  wr_row;
  logic  wr_en;

  // write-back wins the internal port
  assign int_addr = wr_en ? wr_addr : rd_addr;

  // read data shows up one cycle after the issue
  always_ff @(posedge clk) begin
    if (reset) begin
      in_valid <= 1'b0;
    end else begin
      in_valid <= rd_issue;
    end
  end

  ////////////////////////////////////////////////////////////
  // shared scratch memory
  ////////////////////////////////////////////////////////////

  dp_ram ram_i (
    .clk       (clk),
    .int_addr  (int_addr),
    .int_wdata (wr_row),
    .int_we    (wr_en),
    .int_rdata (int_rdata),
    .ext_addr  (ext_addr),
    .ext_wdata (ext_wdata),
    .ext_we    (ext_we),
    .ext_rdata (ext_rdata)
  );

  ////////////////////////////////////////////////////////////
  // run control and row fetch
  ////////////////////////////////////////////////////////////

  tpu_control control_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .num_rows  (num_rows),
    .wr_en     (wr_en),
    .run_start (run_start),
    .busy      (busy),
    .done      (done)
  );

  row_reader reader_i (
    .clk        (clk),
    .reset      (reset),
    .run_start  (run_start),
    .src_addr   (src_addr),
    .src_stride (src_stride),
    .num_rows   (num_rows),
    .port_busy  (wr_en),
    .rd_addr    (rd_addr),
    .rd_issue   (rd_issue)
  );

  ////////////////////////////////////////////////////////////
  // normalize, activate, write back
  ////////////////////////////////////////////////////////////

  norm_act #(
    .NORM_SHIFT (NORM_SHIFT)
  ) norm_act_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_row      (int_rdata),
    .mean        (mean),
    .inv_var     (inv_var),
    .norm_enable (norm_enable),
    .relu_enable (relu_enable),
    .out_valid   (out_valid),
    .out_row     (out_row)
  );

  result_writer writer_i (
    .clk        (clk),
    .reset      (reset),
    .run_start  (run_start),
    .dst_addr   (dst_addr),
    .dst_stride (dst_stride),
    .out_valid  (out_valid),
    .out_row    (out_row),
    .wr_addr    (wr_addr),
    .wr_row     (wr_row),
    .wr_en      (wr_en)
  );

  // nothing moves down the pipe unless a run is open
  pipe_inside_run: assert property (
    @(posedge clk) disable iff (reset)
    (in_valid || out_valid || wr_en) |-> busy
  ) else $error("tpu_top: pipeline activity outside a run");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tpu_tb -f sources.f -o tpu_tb_sim

out=$(./obj_dir/tpu_tb_sim)
echo "$out"

# a missing pass line makes grep, and so the script, fail
echo "$out" | grep -q "TESTBENCH PASSED"

// ==== sources.f ====
hdl/tpu_pkg.sv
hdl/dp_ram.sv
hdl/tpu_control.sv
hdl/row_reader.sv
hdl/norm_act.sv
hdl/result_writer.sv
hdl/tpu_top.sv
verification/tpu_tb.sv

// ==== verification/tpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tpu_tb import tpu_pkg::*; ();

  localparam int NORM_SHIFT      = 4;
  localparam int RANDOM_SEED     = 99518;
  localparam int NUM_TESTS       = 5;
  localparam int DONE_LIMIT      = 32 * 8;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 32 * 8 + 200;

  logic    clk;
  logic    reset;
  logic    start;
  logic    done;
  addr_t   src_addr;
  stride_t src_stride;
  addr_t   dst_addr;
  stride_t dst_stride;
  count_t  num_rows;
  lane_t   mean;
  lane_t   inv_var;
  logic    norm_enable;
  logic    relu_enable;
  addr_t   ext_addr;
  row_t    ext_wdata;
  logic    ext_we;
  row_t    ext_rdata;

  // readback bookkeeping shared with the compare process
  logic    read_req;
  logic    req_d;
  logic    relu_mode;
  row_t    exp_q [$];
  addr_t   addr_q [$];
  bit      result_q [$];
  row_t    cmp_row;
  addr_t   cmp_addr;
  bit      cmp_result;
  int      errors;
  int      failed_tests;
  int      test_index;
  int      done_count;

  tpu_top #(
    .NORM_SHIFT (NORM_SHIFT)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .done        (done),
    .src_addr    (src_addr),
    .src_stride  (src_stride),
    .dst_addr    (dst_addr),
    .dst_stride  (dst_stride),
    .num_rows    (num_rows),
    .mean        (mean),
    .inv_var     (inv_var),
    .norm_enable (norm_enable),
    .relu_enable (relu_enable),
    .ext_addr    (ext_addr),
    .ext_wdata   (ext_wdata),
    .ext_we      (ext_we),
    .ext_rdata   (ext_rdata)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // background pattern that mixes the full row address into every lane
  function automatic row_t fill_row(input addr_t a);
    logic [7:0] b;
    b = {2'b10, a};
    return {b ^ 8'h3c, ~b, b + 8'h11, b};
  endfunction

  function automatic row_t expected_row(input row_t src, input lane_t mean_v,
                                        input lane_t inv_v, input bit norm,
                                        input bit relu);
    row_t res;
    int   lane_v;
    for (int i = 0; i < LANES; i++) begin
      lane_v = int'(lane_t'(src[i*DWIDTH +: DWIDTH]));
      if (norm) begin
        lane_v = ((lane_v - int'(mean_v)) * int'(inv_v)) >>> NORM_SHIFT;
        if (lane_v > 127) begin
          lane_v = 127;
        end else if (lane_v < -128) begin
          lane_v = -128;
        end
      end
      if (relu && lane_v < 0) begin
        lane_v = 0;
      end
      res[i*DWIDTH +: DWIDTH] = lane_v[DWIDTH-1:0];
    end
    return res;
  endfunction

  function automatic bit has_negative_lane(input row_t r);
    bit neg;
    neg = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      if (r[i*DWIDTH + DWIDTH - 1]) begin
        neg = 1'b1;
      end
    end
    return neg;
  endfunction

  ////////////////////////////////////////////////////////////
  // host port access
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic host_write(input addr_t a, input row_t d);
    ext_addr  = a;
    ext_wdata = d;
    ext_we    = 1'b1;
    next_cycle();
    ext_we    = 1'b0;
  endtask

  // queue the expected row for the compare process one cycle later
  task automatic host_check(input addr_t a, input row_t exp_v, input bit is_result);
    exp_q.push_back(exp_v);
    addr_q.push_back(a);
    result_q.push_back(is_result);
    ext_addr = a;
    read_req = 1'b1;
    next_cycle();
    read_req = 1'b0;
  endtask

  task automatic wait_for_checks();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  always @(posedge clk) begin
    req_d <= read_req;
    if (!reset && done) begin
      done_count++;
    end
  end

  // read data is registered, so it is settled by the falling edge
  always @(negedge clk) begin
    if (req_d) begin
      cmp_row    = exp_q.pop_front();
      cmp_addr   = addr_q.pop_front();
      cmp_result = result_q.pop_front();
      assert (ext_rdata === cmp_row) else begin
        $display("FAILED ext_rdata row %h: got %h expected %h", cmp_addr, ext_rdata, cmp_row);
        errors++;
      end
      if (relu_mode && cmp_result) begin
        assert (!has_negative_lane(ext_rdata)) else begin
          $display("FAILED ext_rdata row %h has a negative lane: %h", cmp_addr, ext_rdata);
          errors++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // one engine run with preload, start and readback
  ////////////////////////////////////////////////////////////

  task automatic run_test(input string name, input int src_base, input int src_step,
                          input int dst_base, input int dst_step, input int rows,
                          input lane_t mean_v, input lane_t inv_v, input bit norm,
                          input bit relu, input bit saturate, input bit restart);
    row_t  src_rows [0:31];
    int    span;
    int    offset;
    int    k;
    int    err_before;
    int    done_before;
    int    waited;
    bit    seen;
    addr_t a;
    err_before = errors;
    span = rows * dst_step + 4;
    for (offset = 0; offset < span; offset++) begin
      a = addr_t'(dst_base + offset);
      host_write(a, fill_row(a));
    end
    for (k = 0; k < rows; k++) begin
      src_rows[k] = row_t'($urandom);
      // lanes 1 and 2 sit at the input limits to push both saturation bounds
      if (saturate && k == 0) begin
        src_rows[k] = {8'h00, 8'h7f, 8'h80, 8'h05};
      end
      host_write(addr_t'(src_base + k * src_step), src_rows[k]);
    end
    src_addr    = addr_t'(src_base);
    src_stride  = stride_t'(src_step);
    dst_addr    = addr_t'(dst_base);
    dst_stride  = stride_t'(dst_step);
    num_rows    = count_t'(rows);
    mean        = mean_v;
    inv_var     = inv_v;
    norm_enable = norm;
    relu_enable = relu;
    relu_mode   = relu;
    done_before = done_count;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    if (restart) begin
      repeat (3) next_cycle();
      start = 1'b1;
      next_cycle();
      start = 1'b0;
    end
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < DONE_LIMIT) begin
      if (done) begin
        seen = 1'b1;
      end else begin
        next_cycle();
        waited++;
      end
    end
    assert (seen) else begin
      $display("test %0d: engine did not raise done within %0d cycles", test_index + 1,
               DONE_LIMIT);
      errors++;
    end
    repeat (8) next_cycle();
    assert (done_count == done_before + 1) else begin
      $display("test %0d: expected exactly one done pulse but counted %0d", test_index + 1,
               done_count - done_before);
      errors++;
    end
    for (offset = 0; offset < span; offset++) begin
      a = addr_t'(dst_base + offset);
      if (offset % dst_step == 0 && offset / dst_step < rows) begin
        host_check(a, expected_row(src_rows[offset / dst_step], mean_v, inv_v, norm, relu),
                   1'b1);
      end else begin
        host_check(a, fill_row(a), 1'b0);
      end
    end
    wait_for_checks();
    test_index++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", test_index, name);
    end else begin
      $display("test %0d %s: %0d errors", test_index, name, errors - err_before);
      failed_tests++;
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    src_addr     = '0;
    src_stride   = '0;
    dst_addr     = '0;
    dst_stride   = '0;
    num_rows     = '0;
    mean         = '0;
    inv_var      = '0;
    norm_enable  = 1'b0;
    relu_enable  = 1'b0;
    ext_addr     = '0;
    ext_wdata    = '0;
    ext_we       = 1'b0;
    read_req     = 1'b0;
    relu_mode    = 1'b0;
    errors       = 0;
    failed_tests = 0;
    test_index   = 0;
    done_count   = 0;
    void'($urandom(RANDOM_SEED));
    repeat (4) @(posedge clk);
    #0.5;
    reset = 1'b0;
    next_cycle();

    run_test("copy", 0, 1, 16, 1, 8, 8'sd0, 8'sd0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("normalize", 28, 1, 36, 1, 6, -8'sd6, 8'sd37, 1'b1, 1'b0, 1'b1, 1'b0);
    run_test("relu", 44, 1, 52, 1, 6, 8'sd3, -8'sd21, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("strided", 1, 3, 20, 2, 5, 8'sd0, 8'sd0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("restart ignored", 40, 1, 2, 1, 5, 8'sd12, 8'sd25, 1'b1, 1'b0, 1'b0, 1'b1);

    $display("summary: %0d tests, %0d failed, %0d check errors", test_index, failed_tests,
             errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
